//--- common/fight_pkg.sv
package fight_pkg;

    typedef logic [2:0] meter_t;    // Thermometer, shifts right on damage
    typedef logic [4:0] frame_t;
    typedef logic [7:0] sec_t;
    typedef logic [6:0] seg_t;      // Active low, segment 6 in bit 6
    typedef logic [9:0] led_t;

    typedef enum logic [3:0] {
        CS_IDLE,
        CS_LEFT,
        CS_RIGHT,
        CS_ATK_START,
        CS_ATK_ACTIVE,
        CS_ATK_RECOVERY,
        CS_DIR_START,
        CS_DIR_ACTIVE,
        CS_DIR_RECOVERY,
        CS_STUN
    } char_state_e;

    typedef enum logic [1:0] {
        HS_NOHIT,
        HS_HITSTUN,
        HS_BLOCKSTUN
    } hit_state_e;

    typedef enum logic [2:0] {
        FS_IDLE,
        FS_COUNTDOWN,
        FS_ACTIVE,
        FS_END_P1,
        FS_END_P2,
        FS_END_DRAW
    } fight_state_e;

    typedef enum logic {
        GS_MENU,
        GS_GAME
    } game_state_e;

    localparam int TICKS_PER_SEC   = 60;
    localparam int COUNTDOWN_SEC   = 3;
    localparam int ROUND_END_SEC   = 102;   // 99 s of fighting after countdown
    localparam int RESULT_HOLD_SEC = 10;
    localparam int LED_FLASH_TICKS = 30;

    localparam meter_t METER_FULL = 3'b111;

    // Load-frame bonus added to the attacker's frame count
    localparam int HIT_BONUS       = 15;
    localparam int HIT_BONUS_DIR   = 14;
    localparam int BLOCK_BONUS     = 13;
    localparam int BLOCK_BONUS_DIR = 12;

    // Six-digit screens, hex5 in the top bits
    localparam seg_t        SEG_BLANK  = 7'b1111111;
    localparam logic [41:0] SEG_FIGHT  = 42'b0001110_1001111_0000010_0001001_1111000_1001110;
    localparam logic [41:0] SEG_1P     = 42'b1111111_1111111_1111001_0001100_1111111_1111111;
    localparam logic [41:0] SEG_2P     = 42'b1111111_1111111_0100100_0001100_1111111_1111111;
    // Three-digit result tags for hex5 to hex3
    localparam logic [20:0] SEG_WIN_1P = 21'b0001100_1111001_0111111;
    localparam logic [20:0] SEG_WIN_2P = 21'b0001100_0100100_0111111;
    localparam logic [20:0] SEG_DRAW   = 21'b0000110_0011000_0111111;

endpackage

//--- design/game_controller.sv
module game_controller (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_btn,
    input  logic                    mode_switch,
    input  fight_pkg::char_state_e  char1_state,
    input  fight_pkg::hit_state_e   char1_frame_state,
    input  fight_pkg::frame_t       char1_frame_count,
    input  fight_pkg::char_state_e  char2_state,
    input  fight_pkg::hit_state_e   char2_frame_state,
    input  fight_pkg::frame_t       char2_frame_count,
    output fight_pkg::frame_t       char1_load_frame,
    output fight_pkg::frame_t       char2_load_frame,
    output fight_pkg::meter_t       char1_health,
    output fight_pkg::meter_t       char2_health,
    output fight_pkg::meter_t       char1_block,
    output fight_pkg::meter_t       char2_block,
    output fight_pkg::led_t         ledr,
    output fight_pkg::seg_t         hex0,
    output fight_pkg::seg_t         hex1,
    output fight_pkg::seg_t         hex2,
    output fight_pkg::seg_t         hex3,
    output fight_pkg::seg_t         hex4,
    output fight_pkg::seg_t         hex5,
    output fight_pkg::game_state_e  game_state,
    output fight_pkg::fight_state_e fight_state,
    output logic                    input_active,
    output logic                    mode_selected,
    output fight_pkg::sec_t         second_count
);
    import fight_pkg::*;

    logic fight_enable;
    logic timer_clear;
    logic timer_enable;
    logic resolve_enable;
    logic meter_load;
    logic match_over;    // Set once the round has ended
    logic in_end;
    sec_t finish_time;
    logic [$clog2(LED_FLASH_TICKS)-1:0] flash_count;

    assign fight_enable = (game_state == GS_GAME);
    assign in_end = (fight_state == FS_END_P1) || (fight_state == FS_END_P2) ||
                    (fight_state == FS_END_DRAW);

    second_timer u_second_timer (
        .clk(clk), .rst(rst), .clear(timer_clear), .enable(timer_enable),
        .second_count(second_count)
    );

    fight_controller u_fight_controller (
        .clk(clk), .rst(rst), .fight_enable(fight_enable), .start_btn(start_btn),
        .char1_health(char1_health), .char2_health(char2_health),
        .timer_clear(timer_clear), .timer_enable(timer_enable),
        .resolve_enable(resolve_enable), .meter_load(meter_load),
        .input_active(input_active), .second_count(second_count),
        .fight_state(fight_state), .finish_time(finish_time)
    );

    hit_resolver u_hit_resolver (
        .clk(clk), .rst(rst), .resolve_enable(resolve_enable), .meter_load(meter_load),
        .char1_state(char1_state), .char2_state(char2_state),
        .char1_frame_state(char1_frame_state), .char2_frame_state(char2_frame_state),
        .char1_frame_count(char1_frame_count), .char2_frame_count(char2_frame_count),
        .char1_load_frame(char1_load_frame), .char2_load_frame(char2_load_frame),
        .char1_health(char1_health), .char2_health(char2_health),
        .char1_block(char1_block), .char2_block(char2_block)
    );

    score_display u_score_display (
        .clk(clk), .rst(rst), .game_state(game_state), .mode_selected(mode_selected),
        .fight_state(fight_state), .finish_time(finish_time),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state    <= GS_MENU;
            mode_selected <= 1'b0;
            match_over    <= 1'b0;
            ledr          <= '0;
            flash_count   <= '0;
        end else if (game_state == GS_MENU) begin
            mode_selected <= mode_switch;   // Track the switch until start
            ledr          <= '0;
            if (start_btn) begin
                game_state <= GS_GAME;
            end
        end else if (match_over) begin
            if (fight_state == FS_IDLE) begin
                game_state <= GS_MENU;
                match_over <= 1'b0;
            end else if (flash_count == LED_FLASH_TICKS - 1) begin
                flash_count <= '0;
                ledr        <= ~ledr;
            end else begin
                flash_count <= flash_count + 1'b1;
            end
        end else if (in_end) begin
            match_over  <= 1'b1;
            ledr        <= '1;   // Flash starts from all on
            flash_count <= '0;
        end else if (fight_state == FS_ACTIVE) begin
            // Player 1 bar mirrored so both bars drain toward the centre
            ledr <= {char1_health[0], char1_health[1], char1_health[2], 4'b0000, char2_health};
        end
    end

endmodule

//--- design/second_timer.sv
module second_timer (
    input  logic            clk,
    input  logic            rst,
    input  logic            clear,
    input  logic            enable,
    output fight_pkg::sec_t second_count
);
    import fight_pkg::*;

    logic [$clog2(TICKS_PER_SEC)-1:0] tick_count;   // Cycles within the current second

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_count   <= '0;
            second_count <= '0;
        end else if (clear) begin
            tick_count   <= '0;
            second_count <= '0;
        end else if (enable) begin
            if (tick_count == TICKS_PER_SEC - 1) begin
                tick_count   <= '0;
                second_count <= second_count + 1'b1;   // One full second elapsed
            end else begin
                tick_count <= tick_count + 1'b1;
            end
        end
    end

endmodule

//--- display/score_display.sv
module score_display (
    input  logic                    clk,
    input  logic                    rst,
    input  fight_pkg::game_state_e  game_state,
    input  logic                    mode_selected,
    input  fight_pkg::fight_state_e fight_state,
    input  fight_pkg::sec_t         finish_time,
    output fight_pkg::seg_t         hex0,
    output fight_pkg::seg_t         hex1,
    output fight_pkg::seg_t         hex2,
    output fight_pkg::seg_t         hex3,
    output fight_pkg::seg_t         hex4,
    output fight_pkg::seg_t         hex5
);
    import fight_pkg::*;

    logic [3:0] tens;
    logic [3:0] ones;
    seg_t       tens_seg;
    seg_t       ones_seg;

    function automatic seg_t digit_seg(logic [3:0] d);
        case (d)          // 6543210
            4'd0:    digit_seg = 7'b1000000;
            4'd1:    digit_seg = 7'b1111001;
            4'd2:    digit_seg = 7'b0100100;
            4'd3:    digit_seg = 7'b0110000;
            4'd4:    digit_seg = 7'b0011001;
            4'd5:    digit_seg = 7'b0010010;
            4'd6:    digit_seg = 7'b0000010;
            4'd7:    digit_seg = 7'b1111000;
            4'd8:    digit_seg = 7'b0000000;
            4'd9:    digit_seg = 7'b0010000;
            default: digit_seg = SEG_BLANK;
        endcase
    endfunction

    assign tens     = 4'((finish_time / 8'd10) % 8'd10);
    assign ones     = 4'(finish_time % 8'd10);
    assign tens_seg = digit_seg(tens);
    assign ones_seg = digit_seg(ones);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {hex5, hex4, hex3, hex2, hex1, hex0} <= {6{SEG_BLANK}};
        end else if (game_state == GS_MENU) begin
            {hex5, hex4, hex3, hex2, hex1, hex0} <= mode_selected ? SEG_1P : SEG_2P;
        end else begin
            case (fight_state)
                FS_END_P1: begin
                    {hex5, hex4, hex3, hex2, hex1, hex0} <=
                        {SEG_WIN_1P, tens_seg, ones_seg, SEG_BLANK};
                end
                FS_END_P2: begin
                    {hex5, hex4, hex3, hex2, hex1, hex0} <=
                        {SEG_WIN_2P, tens_seg, ones_seg, SEG_BLANK};
                end
                FS_END_DRAW: begin
                    {hex5, hex4, hex3, hex2, hex1, hex0} <=
                        {SEG_DRAW, tens_seg, ones_seg, SEG_BLANK};
                end
                default: {hex5, hex4, hex3, hex2, hex1, hex0} <= SEG_FIGHT;
            endcase
        end
    end

endmodule

//--- fight/fight_controller.sv
module fight_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fight_enable,
    input  logic                   start_btn,
    input  fight_pkg::meter_t      char1_health,
    input  fight_pkg::meter_t      char2_health,
    output logic                   timer_clear,
    output logic                   timer_enable,
    output logic                   resolve_enable,
    output logic                   meter_load,
    output logic                   input_active,
    input  fight_pkg::sec_t        second_count,
    output fight_pkg::fight_state_e fight_state,
    output fight_pkg::sec_t        finish_time
);
    import fight_pkg::*;

    logic enable_q;      // Previous fight_enable for edge detect
    logic enable_rise;
    logic char1_out;
    logic char2_out;
    logic time_up;
    logic hold_done;
    logic in_end;

    assign enable_rise = fight_enable & ~enable_q;
    assign char1_out   = (char1_health == '0);
    assign char2_out   = (char2_health == '0);
    assign time_up     = (second_count == ROUND_END_SEC);
    assign hold_done   = (second_count >= finish_time + COUNTDOWN_SEC + RESULT_HOLD_SEC);
    assign in_end      = (fight_state == FS_END_P1) || (fight_state == FS_END_P2) ||
                         (fight_state == FS_END_DRAW);

    assign timer_clear    = (fight_state == FS_IDLE);
    assign timer_enable   = (fight_state != FS_IDLE);   // Keeps counting through the result hold
    assign resolve_enable = (fight_state == FS_ACTIVE);
    assign input_active   = (fight_state == FS_ACTIVE);
    assign meter_load     = (fight_state == FS_IDLE) & enable_rise;   // Refill at round start

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fight_state <= FS_IDLE;
            finish_time <= '0;
            enable_q    <= 1'b0;
        end else begin
            enable_q <= fight_enable;
            if (!fight_enable) begin
                fight_state <= FS_IDLE;
            end else begin
                case (fight_state)
                    FS_IDLE: begin
                        // Only a fresh enable starts a round, not a lingering one
                        if (enable_rise) begin
                            fight_state <= FS_COUNTDOWN;
                        end
                    end
                    FS_COUNTDOWN: begin
                        if (second_count == COUNTDOWN_SEC) begin
                            fight_state <= FS_ACTIVE;
                        end
                    end
                    FS_ACTIVE: begin
                        if (char1_out || char2_out || time_up) begin
                            finish_time <= second_count - sec_t'(COUNTDOWN_SEC);
                            if (char1_out && char2_out) begin
                                fight_state <= FS_END_DRAW;   // Double KO
                            end else if (char1_out) begin
                                fight_state <= FS_END_P2;
                            end else if (char2_out) begin
                                fight_state <= FS_END_P1;
                            end else begin
                                fight_state <= FS_END_DRAW;   // Time out
                            end
                        end
                    end
                    default: begin
                        if (!in_end || start_btn || hold_done) begin
                            fight_state <= FS_IDLE;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- fight/hit_resolver.sv
module hit_resolver (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  resolve_enable,
    input  logic                  meter_load,
    input  fight_pkg::char_state_e char1_state,
    input  fight_pkg::char_state_e char2_state,
    input  fight_pkg::hit_state_e  char1_frame_state,
    input  fight_pkg::hit_state_e  char2_frame_state,
    input  fight_pkg::frame_t      char1_frame_count,
    input  fight_pkg::frame_t      char2_frame_count,
    output fight_pkg::frame_t      char1_load_frame,
    output fight_pkg::frame_t      char2_load_frame,
    output fight_pkg::meter_t      char1_health,
    output fight_pkg::meter_t      char2_health,
    output fight_pkg::meter_t      char1_block,
    output fight_pkg::meter_t      char2_block
);
    import fight_pkg::*;

    hit_state_e char1_prev;
    hit_state_e char2_prev;
    logic       char1_hit;
    logic       char2_hit;
    logic       char1_blk;
    logic       char2_blk;

    // Recovery frame for a victim of a clean hit
    function automatic frame_t hit_frame(char_state_e atk, frame_t cnt, frame_t cur);
        case (atk)
            CS_ATK_ACTIVE, CS_ATK_RECOVERY: hit_frame = cnt + frame_t'(HIT_BONUS);
            CS_DIR_ACTIVE, CS_DIR_RECOVERY: hit_frame = cnt + frame_t'(HIT_BONUS_DIR);
            default:                        hit_frame = cur;
        endcase
    endfunction

    // Blocked attacks only count while the attacker is in an active frame
    function automatic frame_t block_frame(char_state_e atk, frame_t cnt, frame_t cur);
        case (atk)
            CS_ATK_ACTIVE: block_frame = cnt + frame_t'(BLOCK_BONUS);
            CS_DIR_ACTIVE: block_frame = cnt + frame_t'(BLOCK_BONUS_DIR);
            default:       block_frame = cur;
        endcase
    endfunction

    assign char1_hit = (char1_frame_state == HS_HITSTUN)   && (char1_prev == HS_NOHIT);
    assign char2_hit = (char2_frame_state == HS_HITSTUN)   && (char2_prev == HS_NOHIT);
    assign char1_blk = (char1_frame_state == HS_BLOCKSTUN) && (char1_prev == HS_NOHIT);
    assign char2_blk = (char2_frame_state == HS_BLOCKSTUN) && (char2_prev == HS_NOHIT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            char1_prev       <= HS_NOHIT;
            char2_prev       <= HS_NOHIT;
            char1_health     <= METER_FULL;
            char2_health     <= METER_FULL;
            char1_block      <= METER_FULL;
            char2_block      <= METER_FULL;
            char1_load_frame <= '0;
            char2_load_frame <= '0;
        end else begin
            char1_prev <= char1_frame_state;
            char2_prev <= char2_frame_state;
            if (meter_load) begin
                char1_health <= METER_FULL;
                char2_health <= METER_FULL;
                char1_block  <= METER_FULL;
                char2_block  <= METER_FULL;
            end else if (resolve_enable) begin
                if (char1_hit) begin
                    char1_health     <= char1_health >> 1;
                    char1_load_frame <= hit_frame(char2_state, char2_frame_count, char1_load_frame);
                end else if (char1_blk) begin
                    char1_block      <= char1_block >> 1;
                    char1_load_frame <= block_frame(char2_state, char2_frame_count,
                                                    char1_load_frame);
                end
                if (char2_hit) begin
                    char2_health     <= char2_health >> 1;
                    char2_load_frame <= hit_frame(char1_state, char1_frame_count, char2_load_frame);
                end else if (char2_blk) begin
                    char2_block      <= char2_block >> 1;
                    char2_load_frame <= block_frame(char1_state, char1_frame_count,
                                                    char2_load_frame);
                end
                if (char1_frame_state == HS_NOHIT && char2_frame_state == HS_NOHIT) begin
                    char1_load_frame <= '0;   // Both recovered
                    char2_load_frame <= '0;
                end
            end
        end
    end

endmodule

//--- verif/game_asserts.sv
module game_asserts (
    input logic                    clk,
    input logic                    rst,
    input logic                    input_active,
    input fight_pkg::fight_state_e fight_state,
    input fight_pkg::game_state_e  game_state,
    input fight_pkg::sec_t         second_count,
    input fight_pkg::meter_t       char1_health,
    input fight_pkg::meter_t       char2_health,
    input fight_pkg::meter_t       char1_block,
    input fight_pkg::meter_t       char2_block
);
    import fight_pkg::*;

    // Inputs open only between the end of the countdown and the time limit
    a_input_active: assert property (@(posedge clk) disable iff (rst)
        input_active |-> (fight_state == FS_ACTIVE && game_state == GS_GAME &&
                          second_count >= COUNTDOWN_SEC && second_count <= ROUND_END_SEC))
        else $error("input_active outside the active round");

    // Meters only drain during a round
    a_health_drains: assert property (@(posedge clk) disable iff (rst)
        ($past(fight_state) == FS_ACTIVE && fight_state == FS_ACTIVE) |->
            (char1_health <= $past(char1_health) && char2_health <= $past(char2_health)))
        else $error("health meter increased while active");

    a_block_drains: assert property (@(posedge clk) disable iff (rst)
        ($past(fight_state) == FS_ACTIVE && fight_state == FS_ACTIVE) |->
            (char1_block <= $past(char1_block) && char2_block <= $past(char2_block)))
        else $error("block meter increased while active");

    a_reset_menu: assert property (@(posedge clk)
        rst |=> (game_state == GS_MENU))
        else $error("game_state not menu after reset");

endmodule

bind game_controller game_asserts u_game_asserts (
    .clk(clk),
    .rst(rst),
    .input_active(input_active),
    .fight_state(fight_state),
    .game_state(game_state),
    .second_count(second_count),
    .char1_health(char1_health),
    .char2_health(char2_health),
    .char1_block(char1_block),
    .char2_block(char2_block)
);

//--- verif/tb_game.sv
module tb_game;
    import fight_pkg::*;

    localparam seg_t SEG_D0 = 7'b1000000;
    localparam seg_t SEG_D9 = 7'b0010000;

    logic         clk;
    logic         rst;
    logic         start_btn;
    logic         mode_switch;
    char_state_e  c1_state;
    char_state_e  c2_state;
    hit_state_e   c1_fs;
    hit_state_e   c2_fs;
    frame_t       c1_cnt;
    frame_t       c2_cnt;
    frame_t       c1_load;
    frame_t       c2_load;
    meter_t       c1_health;
    meter_t       c2_health;
    meter_t       c1_block;
    meter_t       c2_block;
    led_t         ledr;
    seg_t         hex0;
    seg_t         hex1;
    seg_t         hex2;
    seg_t         hex3;
    seg_t         hex4;
    seg_t         hex5;
    game_state_e  game_state;
    fight_state_e fight_state;
    logic         input_active;
    logic         mode_selected;
    sec_t         second_count;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          test_errors;
    meter_t      m_health [1:2];   // Reference model state
    meter_t      m_block  [1:2];
    frame_t      m_load   [1:2];

    game_controller u_game_controller (
        .clk(clk), .rst(rst), .start_btn(start_btn), .mode_switch(mode_switch),
        .char1_state(c1_state), .char1_frame_state(c1_fs), .char1_frame_count(c1_cnt),
        .char2_state(c2_state), .char2_frame_state(c2_fs), .char2_frame_count(c2_cnt),
        .char1_load_frame(c1_load), .char2_load_frame(c2_load),
        .char1_health(c1_health), .char2_health(c2_health),
        .char1_block(c1_block), .char2_block(c2_block), .ledr(ledr),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5),
        .game_state(game_state), .fight_state(fight_state), .input_active(input_active),
        .mode_selected(mode_selected), .second_count(second_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};   // One step per bit
        end
    endtask

    task automatic note_fail(input string msg);
        errors++;
        test_errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic check_meter(input string what, input meter_t got, input meter_t exp);
        checks++;
        if (got !== exp) note_fail($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_frame(input string what, input frame_t got, input frame_t exp);
        checks++;
        if (got !== exp) note_fail($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_seg(input string what, input seg_t got, input seg_t exp);
        checks++;
        if (got !== exp) note_fail($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_led(input string what, input led_t got, input led_t exp);
        checks++;
        if (got !== exp) note_fail($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_sec(input string what, input sec_t got, input sec_t exp);
        checks++;
        if (got !== exp) note_fail($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) note_fail($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_fight(input string what, input fight_state_e got,
                               input fight_state_e exp);
        checks++;
        if (got !== exp) note_fail($sformatf("%s got %s expected %s", what, got.name(),
                                             exp.name()));
    endtask

    // Six digits, hex5 in the top bits
    task automatic check_screen(input string what, input logic [41:0] exp);
        check_seg({what, " hex5"}, hex5, exp[41:35]);
        check_seg({what, " hex4"}, hex4, exp[34:28]);
        check_seg({what, " hex3"}, hex3, exp[27:21]);
        check_seg({what, " hex2"}, hex2, exp[20:14]);
        check_seg({what, " hex1"}, hex1, exp[13:7]);
        check_seg({what, " hex0"}, hex0, exp[6:0]);
    endtask

    task automatic wait_fight(input fight_state_e target, input int limit);
        int n;
        n = 0;
        while (fight_state !== target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (fight_state !== target) begin
            $display("Timeout: fight state never reached %s", target.name());
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic wait_menu(input int limit);
        int n;
        n = 0;
        while (game_state !== GS_MENU && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (game_state !== GS_MENU) begin
            $display("Timeout: controller never returned to the menu");
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic press_start();
        start_btn = 1'b1;
        @(negedge clk);
        start_btn = 1'b0;
    endtask

    task automatic refill_model();
        for (int i = 1; i <= 2; i++) begin
            m_health[i] = METER_FULL;
            m_block[i]  = METER_FULL;
            m_load[i]   = '0;
        end
    endtask

    task automatic check_meters(input string what);
        check_meter({what, " health1"}, c1_health, m_health[1]);
        check_meter({what, " health2"}, c2_health, m_health[2]);
        check_meter({what, " block1"}, c1_block, m_block[1]);
        check_meter({what, " block2"}, c2_block, m_block[2]);
    endtask

    // One hit or block on the victim, then both recover
    task automatic apply_event(input int victim, input logic is_hit, input char_state_e atk,
                               input frame_t cnt, input logic check_bar);
        hit_state_e fs;
        fs = is_hit ? HS_HITSTUN : HS_BLOCKSTUN;
        if (victim == 1) begin
            c2_state = atk;
            c2_cnt   = cnt;
            c1_fs    = fs;
        end else begin
            c1_state = atk;
            c1_cnt   = cnt;
            c2_fs    = fs;
        end
        if (is_hit) begin
            m_health[victim] = m_health[victim] >> 1;
            if (atk == CS_ATK_ACTIVE || atk == CS_ATK_RECOVERY) m_load[victim] = cnt + 5'd15;
            else m_load[victim] = cnt + 5'd14;
        end else begin
            m_block[victim] = m_block[victim] >> 1;
            if (atk == CS_ATK_ACTIVE) m_load[victim] = cnt + 5'd13;
            else if (atk == CS_DIR_ACTIVE) m_load[victim] = cnt + 5'd12;
        end
        @(negedge clk);
        check_meters("event");
        check_frame("load1", c1_load, m_load[1]);
        check_frame("load2", c2_load, m_load[2]);
        c1_fs    = HS_NOHIT;
        c2_fs    = HS_NOHIT;
        c1_state = CS_IDLE;
        c2_state = CS_IDLE;
        m_load[1] = '0;
        m_load[2] = '0;
        @(negedge clk);
        check_frame("load1 cleared", c1_load, '0);
        check_frame("load2 cleared", c2_load, '0);
        if (check_bar) begin
            check_led("ledr", ledr, {m_health[1][0], m_health[1][1], m_health[1][2], 4'b0000,
                                     m_health[2]});
        end
    endtask

    task automatic random_event();
        logic [31:0] r;
        int          victim;
        logic        is_hit;
        char_state_e atk;
        get_bits(1, r);
        victim = r[0] ? 2 : 1;
        get_bits(1, r);
        is_hit = r[0];
        get_bits(2, r);
        case (r[1:0])
            2'd0:    atk = CS_ATK_ACTIVE;
            2'd1:    atk = CS_ATK_RECOVERY;
            2'd2:    atk = CS_DIR_ACTIVE;
            default: atk = CS_DIR_RECOVERY;
        endcase
        if (is_hit && m_health[victim] == 3'b001) is_hit = 1'b0;   // Keep both alive
        get_bits(5, r);
        apply_event(victim, is_hit, atk, r[4:0], 1'b1);
    endtask

    task automatic end_test(input string name);
        $display("%-10s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "bad", test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] r;
        lfsr = 32'h4b6929ac;
        errors = 0;
        checks = 0;
        test_errors = 0;
        rst = 1'b1;
        start_btn = 1'b0;
        mode_switch = 1'b0;
        c1_state = CS_IDLE;
        c2_state = CS_IDLE;
        c1_fs = HS_NOHIT;
        c2_fs = HS_NOHIT;
        c1_cnt = '0;
        c2_cnt = '0;
        refill_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        mode_switch = 1'b1;
        repeat (2) @(negedge clk);
        check_flag("mode 1p", mode_selected, 1'b1);
        check_screen("menu 1p", SEG_1P);
        mode_switch = 1'b0;
        repeat (2) @(negedge clk);
        check_flag("mode 2p", mode_selected, 1'b0);
        check_screen("menu 2p", SEG_2P);
        mode_switch = 1'b1;
        @(negedge clk);
        press_start();
        repeat (2) @(negedge clk);
        check_screen("fight", SEG_FIGHT);
        end_test("menu");

        wait_fight(FS_ACTIVE, 4 * TICKS_PER_SEC);
        check_flag("input_active", input_active, 1'b1);
        check_sec("countdown seconds", second_count, sec_t'(COUNTDOWN_SEC));
        check_meters("countdown");
        end_test("countdown");

        repeat (8) random_event();
        end_test("random");

        // Whole knockout stays inside the first second of fighting
        while (m_health[2] != '0) begin
            get_bits(5, r);
            apply_event(2, 1'b1, CS_ATK_ACTIVE, r[4:0], 1'b0);
        end
        wait_fight(FS_END_P1, 20);
        repeat (2) @(negedge clk);
        check_fight("knockout", fight_state, FS_END_P1);
        check_flag("input_active end", input_active, 1'b0);
        check_led("ledr flash", ledr, '1);
        check_screen("result", {SEG_WIN_1P, SEG_D0, SEG_D0, SEG_BLANK});
        end_test("knockout");

        press_start();
        wait_menu(10);
        repeat (2) @(negedge clk);
        check_fight("menu idle", fight_state, FS_IDLE);
        check_sec("timer cleared", second_count, '0);
        check_screen("back 1p", SEG_1P);
        end_test("return");

        refill_model();
        press_start();
        wait_fight(FS_ACTIVE, 4 * TICKS_PER_SEC);
        check_meters("refill");
        wait_fight(FS_END_DRAW, (ROUND_END_SEC + 1) * TICKS_PER_SEC);
        repeat (2) @(negedge clk);
        check_sec("draw seconds", second_count, sec_t'(99 + COUNTDOWN_SEC));
        check_screen("draw", {SEG_DRAW, SEG_D9, SEG_D9, SEG_BLANK});
        wait_menu((RESULT_HOLD_SEC + 2) * TICKS_PER_SEC);
        end_test("timeout");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/fight_pkg.sv
design/second_timer.sv
fight/fight_controller.sv
fight/hit_resolver.sv
display/score_display.sv
design/game_controller.sv
verif/game_asserts.sv
verif/tb_game.sv
